// ==== Makefile ====
# Verilator build and run for the mesh router testbench
VERILATOR ?= verilator
TOP       ?= meshRouterTb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell grep -v '^+' build.f) include/nocDefines.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): build.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f build.f --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== build.f ====
+incdir+include
verilog/nocPkg.sv
verilog/flitFifo.sv
verilog/lbdrRoute.sv
verilog/inputUnit.sv
verilog/outputUnit.sv
verilog/routerCfg.sv
verilog/meshRouter.sv
verif/meshRouterTb.sv

// ==== include/nocDefines.svh ====
// Flit kind codes and configuration register byte offsets
// Shared by the router package and the testbench
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// Flit kinds, 3 bits wide
// Code 0 marks no valid flit kind
`define HEADER 3'd1
`define BODY   3'd2
`define TAIL   3'd3

// Byte offsets on the AXI4-Lite configuration slave
`define ROUTE_BITS 4'h0
`define CONN_BITS  4'h4
`define LOCAL_ADDR 4'h8
`define DROP_COUNT 4'hC

`endif

// ==== verif/meshRouterTb.sv ====
// Self-checking testbench for the five-port mesh router
// Inputs change and handshakes are sampled on the falling clock edge
// Random stimulus comes from a fixed xorshift seed
// Stops at the first mismatch
`include "nocDefines.svh"

module meshRouterTb;
  timeunit 1ns;
  timeprecision 100ps;
  import nocPkg::*;

  localparam int FifoDepth    = 4;
  localparam int AxiTimeout   = 50;
  // Long enough for a discarded packet to leave a full FIFO
  localparam int SettleCycles = 2 * FifoDepth + 4;

  logic                clk;
  logic                rst;
  logic [3:0]          awaddr;
  logic                awvalid;
  logic                awready;
  logic [31:0]         wdata;
  logic [3:0]          wstrb;
  logic                wvalid;
  logic                wready;
  logic [1:0]          bresp;
  logic                bvalid;
  logic                bready;
  logic [3:0]          araddr;
  logic                arvalid;
  logic                arready;
  logic [31:0]         rdata;
  logic [1:0]          rresp;
  logic                rvalid;
  logic                rready;
  linkT                inLink [NumPorts];
  logic [NumPorts-1:0] inReady;
  linkT                outLink [NumPorts];
  logic [NumPorts-1:0] outReady;

  // Model state
  logic [31:0]         seed;
  routeCfgT            modelCfg;
  flitT                sendQ [NumPorts][$];
  // Expected flits per input and output pair at index input * NumPorts + output
  flitT                expQ [NumPorts*NumPorts][$];
  int                  curIn [NumPorts];
  int                  pktCount [NumPorts];
  logic [NumPorts-1:0] held;
  logic                randomMode;
  int                  dropTally;

  meshRouter #(
    .FifoDepth(FifoDepth)
  ) i_meshRouter (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .inLink(inLink), .inReady(inReady), .outLink(outLink), .outReady(outReady)
  );

  always #50 clk = ~clk;

  task automatic compareValues(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic failRun(string why);
    $display("%s at %0t ns", why, $time);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRand();
    seed = xorshift(seed);
    return seed;
  endfunction

  function automatic flitT makeFlit(logic [2:0] kind, logic [15:0] word);
    return flitT'({kind, word});
  endfunction

  // Expected output port or -1 for a dropped packet
  function automatic int modelRoute(routeCfgT c, nodeAddrT dst);
    int   dx;
    int   dy;
    int   vert;
    int   horz;
    int   vTurn;
    int   hTurn;
    logic vOk;
    logic hOk;
    dx = int'(dst[1:0]) - int'(c.localAddr[1:0]);
    dy = int'(dst[3:2]) - int'(c.localAddr[3:2]);
    if (dx == 0 && dy == 0) begin
      return 4;
    end
    // Port numbers N 0 E 1 W 2 S 3 match the connectivity bit order
    vert = (dy < 0) ? 0 : ((dy > 0) ? 3 : -1);
    horz = (dx > 0) ? 1 : ((dx < 0) ? 2 : -1);
    if (horz < 0) begin
      return c.connBits[vert] ? vert : -1;
    end
    if (vert < 0) begin
      return c.connBits[horz] ? horz : -1;
    end
    // Turn bits ne nw en es wn ws se sw
    vTurn = (vert == 0) ? ((horz == 1) ? 0 : 1) : ((horz == 1) ? 6 : 7);
    hTurn = (horz == 1) ? ((vert == 0) ? 2 : 3) : ((vert == 0) ? 4 : 5);
    vOk = c.routeBits[vTurn] && c.connBits[vert];
    hOk = c.routeBits[hTurn] && c.connBits[horz];
    if (vOk && hOk) begin
      return (vert < horz) ? vert : horz;
    end else if (vOk) begin
      return vert;
    end else if (hOk) begin
      return horz;
    end
    return -1;
  endfunction

  // Queue one packet on input p and record where the model expects it
  task automatic sendPacket(int p, nodeAddrT dst, int nBody);
    logic [31:0] r;
    logic [7:0]  tag;
    flitT        f;
    int          q;
    r   = nextRand();
    tag = {3'(p), 5'(pktCount[p])};
    pktCount[p]++;
    q = modelRoute(modelCfg, dst);
    if (q < 0) begin
      dropTally++;
    end
    for (int i = 0; i < nBody + 2; i++) begin
      if (i == 0) begin
        f = makeFlit(`HEADER, {dst, r[3:0], tag});
      end else begin
        r = nextRand();
        f = makeFlit((i == nBody + 1) ? `TAIL : `BODY, r[15:0]);
      end
      sendQ[p].push_back(f);
      if (q >= 0) begin
        expQ[p*NumPorts+q].push_back(f);
      end
    end
  endtask

  // A header picks the input whose packet it starts
  // Later flits must come from that same input
  task automatic scoreFlit(int q, flitT f);
    flitT e;
    if (curIn[q] < 0) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (curIn[q] < 0 && expQ[p*NumPorts+q].size() > 0 && expQ[p*NumPorts+q][0] == f) begin
          curIn[q] = p;
        end
      end
    end
    if (curIn[q] < 0) begin
      failRun($sformatf("Unexpected flit %h on output %0d", f, q));
    end else begin
      e = expQ[curIn[q]*NumPorts+q].pop_front();
      compareValues($sformatf("flit on output %0d from input %0d", q, curIn[q]),
                    32'(f), 32'(e));
      if (f.kind == FlitTail) begin
        curIn[q] = -1;
      end
    end
  endtask

  // One clock of link traffic
  task automatic stepCycle();
    logic [31:0] r;
    @(negedge clk);
    for (int p = 0; p < NumPorts; p++) begin
      r = nextRand();
      // A held flit keeps valid high until it is taken
      inLink[p].valid = (sendQ[p].size() > 0) && (held[p] || !randomMode || r[1:0] != 2'b00);
      if (inLink[p].valid) begin
        inLink[p].flit = sendQ[p][0];
      end
      held[p] = inLink[p].valid && !inReady[p];
      if (inLink[p].valid && inReady[p]) begin
        void'(sendQ[p].pop_front());
      end
    end
    for (int q = 0; q < NumPorts; q++) begin
      r = nextRand();
      outReady[q] = !randomMode || r[3:2] != 2'b00;
      if (outLink[q].valid && outReady[q]) begin
        scoreFlit(q, outLink[q].flit);
      end
    end
  endtask

  function automatic logic allIdle();
    logic idle;
    idle = 1'b1;
    for (int i = 0; i < NumPorts * NumPorts; i++) begin
      if (expQ[i].size() > 0) begin
        idle = 1'b0;
      end
    end
    for (int p = 0; p < NumPorts; p++) begin
      if (sendQ[p].size() > 0 || curIn[p] >= 0) begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  task automatic runUntilDrained(int limit);
    int n;
    n = 0;
    while (!allIdle()) begin
      stepCycle();
      n++;
      if (n > limit) begin
        failRun("Traffic did not drain before the timeout");
      end
    end
    for (int i = 0; i < SettleCycles; i++) begin
      stepCycle();
    end
  endtask

  // AXI4-Lite write mirrored into the routing model
  task automatic writeReg(logic [3:0] addr, logic [31:0] data);
    int   n;
    logic awDone;
    logic wDone;
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = 4'hF;
    wvalid  = 1'b1;
    bready  = 1'b1;
    n = 0;
    while (awvalid || wvalid) begin
      awDone = awvalid && awready;
      wDone  = wvalid && wready;
      @(negedge clk);
      if (awDone) begin
        awvalid = 1'b0;
      end
      if (wDone) begin
        wvalid = 1'b0;
      end
      n++;
      if (n > AxiTimeout) begin
        failRun("AXI write address or data was never accepted");
      end
    end
    n = 0;
    while (!bvalid) begin
      @(negedge clk);
      n++;
      if (n > AxiTimeout) begin
        failRun("AXI write response never arrived");
      end
    end
    compareValues("write response", 32'(bresp), 32'd0);
    @(negedge clk);
    bready = 1'b0;
    case (addr)
      `ROUTE_BITS: modelCfg.routeBits = data[7:0];
      `CONN_BITS:  modelCfg.connBits  = data[3:0];
      `LOCAL_ADDR: modelCfg.localAddr = data[3:0];
      default: ;
    endcase
  endtask

  task automatic checkReg(logic [3:0] addr, logic [31:0] exp, string what);
    int n;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    n = 0;
    while (!arready) begin
      @(negedge clk);
      n++;
      if (n > AxiTimeout) begin
        failRun("AXI read address was never accepted");
      end
    end
    @(negedge clk);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid) begin
      @(negedge clk);
      n++;
      if (n > AxiTimeout) begin
        failRun("AXI read data never arrived");
      end
    end
    compareValues("read response", 32'(rresp), 32'd0);
    compareValues(what, rdata, exp);
    @(negedge clk);
    rready = 1'b0;
  endtask

  initial begin
    logic [7:0]  turnSets [4];
    logic [31:0] r;
    turnSets = '{8'h3C, 8'hC3, 8'hFF, 8'h00};
    clk = 1'b0;
    rst = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    outReady = '1;
    held = '0;
    randomMode = 1'b0;
    dropTally = 0;
    seed = 32'hf8af;
    modelCfg = '{routeBits: 8'd60, connBits: 4'd15, localAddr: 4'd5};
    for (int p = 0; p < NumPorts; p++) begin
      inLink[p] = '0;
      curIn[p] = -1;
      pktCount[p] = 0;
    end
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // Reset values
    for (int q = 0; q < NumPorts; q++) begin
      compareValues($sformatf("outLink %0d valid after reset", q), 32'(outLink[q].valid), 0);
    end
    checkReg(`ROUTE_BITS, 32'd60, "route bits after reset");
    checkReg(`CONN_BITS, 32'd15, "connectivity bits after reset");
    checkReg(`LOCAL_ADDR, 32'd5, "local address after reset");
    checkReg(`DROP_COUNT, 32'd0, "drop count after reset");

    // Register readback with upper bits cut to the field width
    writeReg(`ROUTE_BITS, 32'h1A5);
    checkReg(`ROUTE_BITS, 32'hA5, "route bits readback");
    writeReg(`CONN_BITS, 32'hF3);
    checkReg(`CONN_BITS, 32'h3, "connectivity bits readback");
    writeReg(`LOCAL_ADDR, 32'h26);
    checkReg(`LOCAL_ADDR, 32'h6, "local address readback");
    checkReg(4'h2, 32'd0, "unmapped offset 0x2");
    checkReg(4'hE, 32'd0, "unmapped offset 0xE");
    writeReg(`ROUTE_BITS, 32'd60);
    writeReg(`CONN_BITS, 32'd15);
    writeReg(`LOCAL_ADDR, 32'd5);

    // Every destination once
    // Destination 5 is this node and leaves at Local
    for (int d = 0; d < 16; d++) begin
      sendPacket(d % NumPorts, nodeAddrT'(d), d % 3);
      runUntilDrained(200);
    end

    // Diagonal destinations under different turn permissions
    foreach (turnSets[t]) begin
      writeReg(`ROUTE_BITS, 32'(turnSets[t]));
      sendPacket(4, 4'd0, 1);
      sendPacket(4, 4'd2, 1);
      sendPacket(4, 4'd8, 1);
      sendPacket(4, 4'd10, 1);
      runUntilDrained(400);
    end
    writeReg(`ROUTE_BITS, 32'd60);
    checkReg(`DROP_COUNT, 32'(dropTally), "drop count after turn tests");

    // One link at a time marked as missing
    for (int b = 0; b < 4; b++) begin
      writeReg(`CONN_BITS, 32'(4'hF & ~(4'h1 << b)));
      for (int d = 0; d < 16; d++) begin
        sendPacket(d % NumPorts, nodeAddrT'(d), 1);
      end
      runUntilDrained(1000);
      checkReg(`DROP_COUNT, 32'(dropTally), $sformatf("drop count with link %0d off", b));
    end

    // Random traffic with back-pressure
    // East link off so some packets drop
    writeReg(`CONN_BITS, 32'hD);
    randomMode = 1'b1;
    for (int i = 0; i < 40; i++) begin
      for (int p = 0; p < NumPorts; p++) begin
        r = nextRand();
        sendPacket(p, r[3:0], int'(r[9:8]) % 3);
      end
    end
    runUntilDrained(20000);
    randomMode = 1'b0;
    checkReg(`DROP_COUNT, 32'(dropTally), "drop count after random traffic");
    writeReg(`CONN_BITS, 32'd15);

    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== verilog/flitFifo.sv ====
// Synchronous flit FIFO with first-word fall-through read data
// FifoDepth must be at least 2
// Writing when full or reading when empty is not allowed
module flitFifo #(
  parameter int FifoDepth = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         wrEn,
  input  nocPkg::flitT wrData,
  input  logic         rdEn,
  output nocPkg::flitT rdData,
  output logic         empty,
  output logic         full
);
  import nocPkg::*;

  localparam int AddrW = $clog2(FifoDepth);
  localparam int CntW  = $clog2(FifoDepth + 1);

  flitT             mem [FifoDepth];
  logic [AddrW-1:0] wrPtr;
  logic [AddrW-1:0] rdPtr;
  logic [CntW-1:0]  count;

  assign empty  = (count == '0);
  assign full   = (count == CntW'(FifoDepth));
  // Head entry is visible without a read strobe
  assign rdData = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      // Pointers wrap at the depth, which need not be a power of two
      if (wrEn) begin
        wrPtr <= (wrPtr == AddrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (rdEn) begin
        rdPtr <= (rdPtr == AddrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      // Simultaneous write and read leave the count unchanged
      if (wrEn && !rdEn) begin
        count <= count + 1'b1;
      end else if (rdEn && !wrEn) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrPtr] <= wrData;
    end
  end

  assert property (@(posedge clk) disable iff (rst) wrEn |-> !full);
  assert property (@(posedge clk) disable iff (rst) rdEn |-> !empty);

endmodule

// ==== verilog/inputUnit.sv ====
// Router input port with flit FIFO and LBDR route register
// Packets whose route comes out empty are discarded one flit per cycle
// drop pulses once for each discarded header
module inputUnit #(
  parameter int FifoDepth = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  nocPkg::linkT                inLink,
  output logic                        inReady,
  input  nocPkg::routeCfgT            cfg,
  output nocPkg::linkT                head,
  output logic [nocPkg::NumPorts-1:0] req,
  input  logic                        pop,
  output logic                        drop
);
  import nocPkg::*;

  flitT                fifoHead;
  logic                empty;
  logic                full;
  logic                rdEn;
  logic                tailDone;
  logic                discard;
  logic [NumPorts-1:0] route;
  logic                routeValid;

  assign inReady = !full;

  // Routed to nowhere, so drain the packet locally
  assign discard  = routeValid && (route == '0);
  assign rdEn     = pop || (discard && !empty);
  assign tailDone = rdEn && (fifoHead.kind == FlitTail);
  // The header is the first flit drained, so this fires once per packet
  assign drop     = discard && rdEn && (fifoHead.kind == FlitHeader);

  // Head is offered only once its route is known
  assign head.valid = !empty && routeValid && !discard;
  assign head.flit  = fifoHead;
  assign req        = (!empty && routeValid) ? route : '0;

  flitFifo #(
    .FifoDepth(FifoDepth)
  ) i_flitFifo (
    .clk   (clk),
    .rst   (rst),
    .wrEn  (inLink.valid && !full),
    .wrData(inLink.flit),
    .rdEn  (rdEn),
    .rdData(fifoHead),
    .empty (empty),
    .full  (full)
  );

  lbdrRoute i_lbdrRoute (
    .clk       (clk),
    .rst       (rst),
    .cfg       (cfg),
    .headValid (!empty),
    .headFlit  (fifoHead),
    .tailDone  (tailDone),
    .route     (route),
    .routeValid(routeValid)
  );

endmodule

// ==== verilog/lbdrRoute.sv ====
// Logic-based distributed routing with minimal paths only
// No deroutes and no multicast forks
// Route is registered one cycle after a header reaches the head
// and held until the tail leaves
module lbdrRoute (
  input  logic                         clk,
  input  logic                         rst,
  input  nocPkg::routeCfgT             cfg,
  input  logic                         headValid,
  input  nocPkg::flitT                 headFlit,
  input  logic                         tailDone,
  output logic [nocPkg::NumPorts-1:0]  route,
  output logic                         routeValid
);
  import nocPkg::*;

  nodeAddrT            dst;
  logic                goN;
  logic                goE;
  logic                goW;
  logic                goS;
  logic                candN;
  logic                candE;
  logic                candW;
  logic                candS;
  logic [NumPorts-1:0] nextRoute;

  assign dst = headFlit.payload.hdr.dst;

  // Direction flags from comparing destination and local coordinates
  assign goN = dst[3:2] < cfg.localAddr[3:2];
  assign goS = dst[3:2] > cfg.localAddr[3:2];
  assign goE = dst[1:0] > cfg.localAddr[1:0];
  assign goW = dst[1:0] < cfg.localAddr[1:0];

  // Straight moves need only connectivity
  // Diagonal moves also need the turn bit of that candidate
  assign candN = ((goN & ~goE & ~goW) | (goN & goE & cfg.routeBits[0])
                | (goN & goW & cfg.routeBits[1])) & cfg.connBits[0];
  assign candE = ((goE & ~goN & ~goS) | (goE & goN & cfg.routeBits[2])
                | (goE & goS & cfg.routeBits[3])) & cfg.connBits[1];
  assign candW = ((goW & ~goN & ~goS) | (goW & goN & cfg.routeBits[4])
                | (goW & goS & cfg.routeBits[5])) & cfg.connBits[2];
  assign candS = ((goS & ~goE & ~goW) | (goS & goE & cfg.routeBits[6])
                | (goS & goW & cfg.routeBits[7])) & cfg.connBits[3];

  // Lowest port index wins when both diagonal candidates qualify
  always_comb begin
    nextRoute = '0;
    if (!goN && !goE && !goW && !goS) begin
      nextRoute[PortL] = 1'b1;
    end else if (candN) begin
      nextRoute[PortN] = 1'b1;
    end else if (candE) begin
      nextRoute[PortE] = 1'b1;
    end else if (candW) begin
      nextRoute[PortW] = 1'b1;
    end else if (candS) begin
      nextRoute[PortS] = 1'b1;
    end
  end

  // An all-zero route still sets routeValid so the packet gets dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      route      <= '0;
      routeValid <= 1'b0;
    end else if (!routeValid) begin
      if (headValid && headFlit.kind == FlitHeader) begin
        route      <= nextRoute;
        routeValid <= 1'b1;
      end
    end else if (tailDone) begin
      route      <= '0;
      routeValid <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(route));

endmodule

// ==== verilog/meshRouter.sv ====
// Five-port wormhole router for a 4x4 mesh
// Port order N E W S L, links use a plain valid/ready handshake
// Minimum latency is 3 cycles from input handshake to output valid
module meshRouter #(
  parameter int               FifoDepth     = 4,
  parameter logic [7:0]       RouteBitsInit = 8'd60,
  parameter logic [3:0]       ConnBitsInit  = 4'd15,
  parameter nocPkg::nodeAddrT LocalAddrInit = 4'd5
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [3:0]                  awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [31:0]                 wdata,
  input  logic [3:0]                  wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [3:0]                  araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [31:0]                 rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready,
  input  nocPkg::linkT                inLink [nocPkg::NumPorts],
  output logic [nocPkg::NumPorts-1:0] inReady,
  output nocPkg::linkT                outLink [nocPkg::NumPorts],
  input  logic [nocPkg::NumPorts-1:0] outReady
);
  import nocPkg::*;

  routeCfgT                          cfg;
  logic [NumPorts-1:0]               drop;
  linkT                              heads [NumPorts];
  // reqs[i] is the request vector of input i
  logic [NumPorts-1:0][NumPorts-1:0] reqs;
  // pops[q] comes from output q, popCol[i] gathers them per input
  logic [NumPorts-1:0][NumPorts-1:0] pops;
  logic [NumPorts-1:0][NumPorts-1:0] popCol;

  routerCfg #(
    .RouteBitsInit(RouteBitsInit),
    .ConnBitsInit (ConnBitsInit),
    .LocalAddrInit(LocalAddrInit)
  ) i_routerCfg (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .cfg(cfg), .dropPulse(drop)
  );

  for (genvar i = 0; i < NumPorts; i++) begin : genInput
    for (genvar q = 0; q < NumPorts; q++) begin : genPopCol
      assign popCol[i][q] = pops[q][i];
    end

    inputUnit #(
      .FifoDepth(FifoDepth)
    ) i_inputUnit (
      .clk(clk), .rst(rst),
      .inLink(inLink[i]), .inReady(inReady[i]),
      .cfg(cfg), .head(heads[i]), .req(reqs[i]),
      .pop(|popCol[i]), .drop(drop[i])
    );
  end

  // Grant vectors stay inside each output unit
  for (genvar q = 0; q < NumPorts; q++) begin : genOutput
    outputUnit #(
      .OutPort(portIdxT'(q))
    ) i_outputUnit (
      .clk(clk), .rst(rst),
      .heads(heads), .reqs(reqs),
      .outLink(outLink[q]), .outReady(outReady[q]),
      .grant(), .pop(pops[q])
    );
  end

endmodule

// ==== verilog/nocPkg.sv ====
// Types shared by all router blocks
// Node address is {y, x} with 2 bits each, so the mesh is at most 4x4
// Every packet is a header, any number of bodies, then a tail
`include "nocDefines.svh"

package nocPkg;

  // Five ports per router
  localparam int NumPorts = 5;

  // Port order used by every route, request, grant and pop vector
  typedef logic [2:0] portIdxT;
  localparam portIdxT PortN = 3'd0;
  localparam portIdxT PortE = 3'd1;
  localparam portIdxT PortW = 3'd2;
  localparam portIdxT PortS = 3'd3;
  localparam portIdxT PortL = 3'd4;

  // Bits 1:0 are x, bits 3:2 are y
  // North is smaller y, east is larger x
  typedef logic [3:0] nodeAddrT;

  typedef enum logic [2:0] {
    FlitHeader = `HEADER,
    FlitBody   = `BODY,
    FlitTail   = `TAIL
  } flitKindT;

  typedef struct packed {
    nodeAddrT    dst;
    nodeAddrT    src;
    logic [7:0]  seq;
  } headerWordT;

  // Header flits carry addresses, body and tail flits carry raw data
  typedef union packed {
    headerWordT  hdr;
    logic [15:0] raw;
  } flitPayloadU;

  typedef struct packed {
    flitKindT    kind;
    flitPayloadU payload;
  } flitT;

  // Forward half of a link, ready runs back on its own wire
  typedef struct packed {
    logic valid;
    flitT flit;
  } linkT;

  // routeBits from bit 0 up: ne nw en es wn ws se sw
  // connBits from bit 0 up: N E W S
  typedef struct packed {
    logic [7:0] routeBits;
    logic [3:0] connBits;
    nodeAddrT   localAddr;
  } routeCfgT;

  // Register offsets of the configuration slave
  localparam logic [3:0] RegRouteBits = `ROUTE_BITS;
  localparam logic [3:0] RegConnBits  = `CONN_BITS;
  localparam logic [3:0] RegLocalAddr = `LOCAL_ADDR;
  localparam logic [3:0] RegDropCount = `DROP_COUNT;

endpackage

// ==== verilog/outputUnit.sv ====
// Router output port with round-robin arbiter and output register
// Once a header is taken the port stays locked to that input until its tail
// Flits move into the output register when it is empty or being drained
module outputUnit #(
  parameter nocPkg::portIdxT OutPort = 3'd0
) (
  input  logic                                             clk,
  input  logic                                             rst,
  input  nocPkg::linkT                                     heads [nocPkg::NumPorts],
  input  logic [nocPkg::NumPorts-1:0][nocPkg::NumPorts-1:0] reqs,
  output nocPkg::linkT                                     outLink,
  input  logic                                             outReady,
  output logic [nocPkg::NumPorts-1:0]                      grant,
  output logic [nocPkg::NumPorts-1:0]                      pop
);
  import nocPkg::*;

  logic [NumPorts-1:0] reqVec;
  logic                anyReq;
  logic                locked;
  portIdxT             lockIdx;
  portIdxT             lastIdx;
  portIdxT             rrPick;
  portIdxT             winner;
  logic                canLoad;
  logic                xfer;
  logic                outValid;
  flitT                outFlit;

  // Column of the request matrix aimed at this output
  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      reqVec[i] = reqs[i][OutPort];
    end
  end
  assign anyReq = |reqVec;

  // Search starts one past the last winner
  always_comb begin
    int   cand;
    logic found;
    rrPick = lastIdx;
    found  = 1'b0;
    for (int k = 1; k <= NumPorts; k++) begin
      cand = int'(lastIdx) + k;
      if (cand >= NumPorts) begin
        cand = cand - NumPorts;
      end
      if (!found && reqVec[cand]) begin
        rrPick = portIdxT'(cand);
        found  = 1'b1;
      end
    end
  end

  assign winner = locked ? lockIdx : rrPick;

  always_comb begin
    grant = '0;
    if (locked || anyReq) begin
      grant[winner] = 1'b1;
    end
  end

  // Output register accepts a flit when empty or being read
  assign canLoad = !outValid || outReady;
  assign xfer    = (locked || anyReq) && reqVec[winner]
                && heads[winner].valid && canLoad;
  assign pop     = xfer ? grant : '0;

  assign outLink.valid = outValid;
  assign outLink.flit  = outFlit;

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
      locked   <= 1'b0;
      lockIdx  <= PortN;
      // First search after reset begins at North
      lastIdx  <= PortL;
    end else begin
      if (canLoad) begin
        outValid <= xfer;
      end
      if (xfer) begin
        lastIdx <= winner;
        lockIdx <= winner;
        locked  <= (heads[winner].flit.kind != FlitTail);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      outFlit <= heads[winner].flit;
    end
  end

  // A locked output takes no new header before the tail of its packet
  assert property (@(posedge clk) disable iff (rst)
    locked |-> !(xfer && heads[winner].flit.kind == FlitHeader));

endmodule

// ==== verilog/routerCfg.sv ====
// AXI4-Lite configuration slave with a 16-byte register map
// Only byte lane 0 is written, upper write data bits are ignored
// Drop count is read-only and saturates at 16'hFFFF
// Responses are always OKAY, unmapped offsets read as zero
module routerCfg #(
  parameter logic [7:0]       RouteBitsInit = 8'd60,
  parameter logic [3:0]       ConnBitsInit  = 4'd15,
  parameter nocPkg::nodeAddrT LocalAddrInit = 4'd5
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [3:0]                  awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [31:0]                 wdata,
  input  logic [3:0]                  wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [3:0]                  araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [31:0]                 rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready,
  output nocPkg::routeCfgT            cfg,
  input  logic [nocPkg::NumPorts-1:0] dropPulse
);
  import nocPkg::*;

  logic        awHeld;
  logic        wHeld;
  logic [3:0]  awAddrQ;
  logic [7:0]  wByteQ;
  logic        wStrbQ;
  logic        doWrite;
  logic [15:0] dropCount;
  logic [2:0]  dropInc;
  logic [16:0] dropSum;

  // Address and data are taken independently, one of each at a time
  assign awready = !awHeld;
  assign wready  = !wHeld;
  assign bresp   = 2'b00;
  assign rresp   = 2'b00;
  // Single read in flight
  assign arready = !rvalid;
  assign doWrite = awHeld && wHeld && !bvalid;

  always_ff @(posedge clk) begin
    if (rst) begin
      awHeld <= 1'b0;
      wHeld  <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      if (awvalid && awready) begin
        awHeld <= 1'b1;
      end
      if (wvalid && wready) begin
        wHeld <= 1'b1;
      end
      if (doWrite) begin
        awHeld <= 1'b0;
        wHeld  <= 1'b0;
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      awAddrQ <= awaddr;
    end
    if (wvalid && wready) begin
      wByteQ <= wdata[7:0];
      wStrbQ <= wstrb[0];
    end
  end

  // Configuration fields, masked to their widths on write
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg <= '{routeBits: RouteBitsInit, connBits: ConnBitsInit,
               localAddr: LocalAddrInit};
    end else if (doWrite && wStrbQ) begin
      case (awAddrQ)
        RegRouteBits: cfg.routeBits <= wByteQ;
        RegConnBits:  cfg.connBits  <= wByteQ[3:0];
        RegLocalAddr: cfg.localAddr <= wByteQ[3:0];
        default: ;
      endcase
    end
  end

  // Several inputs may drop in the same cycle
  always_comb begin
    dropInc = '0;
    for (int i = 0; i < NumPorts; i++) begin
      dropInc = dropInc + 3'(dropPulse[i]);
    end
  end
  assign dropSum = {1'b0, dropCount} + 17'(dropInc);

  always_ff @(posedge clk) begin
    if (rst) begin
      dropCount <= '0;
    end else begin
      dropCount <= dropSum[16] ? 16'hFFFF : dropSum[15:0];
    end
  end

  // Read data comes one cycle after the AR handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      case (araddr)
        RegRouteBits: rdata <= {24'd0, cfg.routeBits};
        RegConnBits:  rdata <= {28'd0, cfg.connBits};
        RegLocalAddr: rdata <= {28'd0, cfg.localAddr};
        RegDropCount: rdata <= {16'd0, dropCount};
        default:      rdata <= '0;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    $rose(bvalid) |-> $past(awHeld && wHeld));
  assert property (@(posedge clk) disable iff (rst)
    $rose(rvalid) |-> $past(arvalid && arready));

endmodule
